// ==== rtl/eeprom_ctrl_top.sv ====
module eeprom_ctrl_top (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  req_valid,
    input  eeprom_pkg::host_req_t req,
    output logic                  busy,
    output logic                  done,
    output eeprom_pkg::mem_data_t rdata,
    output logic                  ack_error,
    output logic                  scl,
    input  logic                  sda_in,
    output logic                  sda_out,
    output logic                  sda_oe
);
    logic              cmd_valid;
    i2c_pkg::bit_cmd_t cmd;
    logic              cmd_done;
    i2c_pkg::byte_t    rx_byte;
    logic              slave_ack;
    logic              run;
    logic              phase_tick;
    logic [1:0]        quarter;

    eeprom_seq u_seq (
        .CLK       (CLK),
        .RESET     (RESET),
        .req_valid (req_valid),
        .req       (req),
        .busy      (busy),
        .done      (done),
        .rdata     (rdata),
        .ack_error (ack_error),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .cmd_done  (cmd_done),
        .rx_byte   (rx_byte),
        .slave_ack (slave_ack)
    );

    i2c_bit_engine u_bit (
        .CLK        (CLK),
        .RESET      (RESET),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .phase_tick (phase_tick),
        .quarter    (quarter),
        .run        (run),
        .cmd_done   (cmd_done),
        .rx_byte    (rx_byte),
        .slave_ack  (slave_ack),
        .sda_in     (sda_in),
        .sda_out    (sda_out),
        .sda_oe     (sda_oe)
    );

    // free running from reset, scl only moves while run is high
    scl_gen u_scl (
        .CLK        (CLK),
        .RESET      (RESET),
        .run        (run),
        .phase_tick (phase_tick),
        .quarter    (quarter),
        .scl        (scl)
    );

endmodule

// ==== rtl/eeprom_pkg.sv ====
package eeprom_pkg;

    localparam int ADDR_W = 11;       // 2K bytes
    localparam int DATA_W = 8;

    // fixed upper nibble of the control byte
    localparam logic [3:0] DEVICE_CODE = 4'b1010;

    typedef logic [ADDR_W-1:0] mem_addr_t;
    typedef logic [DATA_W-1:0] mem_data_t;

    typedef struct packed {
        logic      is_read;
        mem_addr_t addr;
        mem_data_t wdata;
    } host_req_t;

    typedef enum logic [3:0] {
        IDLE,
        START,
        CTRL_WR,
        ADDR_WR,
        DATA_WR,
        RESTART,
        CTRL_RD,
        DATA_RD,
        STOP,
        FINISH
    } seq_state_e;

endpackage

// ==== rtl/eeprom_seq.sv ====
module eeprom_seq (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  req_valid,
    input  eeprom_pkg::host_req_t req,
    output logic                  busy,
    output logic                  done,
    output eeprom_pkg::mem_data_t rdata,
    output logic                  ack_error,
    output logic                  cmd_valid,
    output i2c_pkg::bit_cmd_t     cmd,
    input  logic                  cmd_done,
    input  i2c_pkg::byte_t        rx_byte,
    input  logic                  slave_ack
);
    eeprom_pkg::seq_state_e state;
    eeprom_pkg::seq_state_e next_state;
    eeprom_pkg::host_req_t  req_q;
    logic                   accept;
    logic                   nacked;

    // bit-engine command issued on entry to state s
    function automatic i2c_pkg::bit_cmd_t cmd_for(
        input eeprom_pkg::seq_state_e s,
        input eeprom_pkg::host_req_t  r
    );
        i2c_pkg::bit_cmd_t c;
        c.op         = i2c_pkg::CMD_WRITE;
        c.tx_byte    = {eeprom_pkg::DEVICE_CODE, r.addr[10:8], 1'b0};
        c.master_ack = 1'b1;    // single byte read ends with nack
        case (s)
            eeprom_pkg::START,
            eeprom_pkg::RESTART: c.op = i2c_pkg::CMD_START;
            eeprom_pkg::ADDR_WR: c.tx_byte = r.addr[7:0];
            eeprom_pkg::DATA_WR: c.tx_byte = r.wdata;
            eeprom_pkg::CTRL_RD: c.tx_byte[0] = 1'b1;
            eeprom_pkg::DATA_RD: c.op = i2c_pkg::CMD_READ;
            eeprom_pkg::STOP:    c.op = i2c_pkg::CMD_STOP;
            default:             c.op = i2c_pkg::CMD_WRITE;    // control byte, write
        endcase
        return c;
    endfunction

    assign busy   = state != eeprom_pkg::IDLE && state != eeprom_pkg::FINISH;
    assign done   = state == eeprom_pkg::FINISH;
    assign accept = req_valid && !busy;

    assign nacked = slave_ack && (state == eeprom_pkg::CTRL_WR || state == eeprom_pkg::ADDR_WR ||
                                  state == eeprom_pkg::DATA_WR || state == eeprom_pkg::CTRL_RD);

    always_comb
    begin
        next_state = state;
        case (state)
            eeprom_pkg::START:   next_state = eeprom_pkg::CTRL_WR;
            eeprom_pkg::CTRL_WR: next_state = nacked ? eeprom_pkg::STOP : eeprom_pkg::ADDR_WR;
            eeprom_pkg::ADDR_WR:
            begin
                if (nacked)
                    next_state = eeprom_pkg::STOP;
                else if (req_q.is_read)
                    next_state = eeprom_pkg::RESTART;
                else
                    next_state = eeprom_pkg::DATA_WR;
            end
            eeprom_pkg::DATA_WR: next_state = eeprom_pkg::STOP;
            eeprom_pkg::RESTART: next_state = eeprom_pkg::CTRL_RD;
            eeprom_pkg::CTRL_RD: next_state = nacked ? eeprom_pkg::STOP : eeprom_pkg::DATA_RD;
            eeprom_pkg::DATA_RD: next_state = eeprom_pkg::STOP;
            eeprom_pkg::STOP:    next_state = eeprom_pkg::FINISH;
            default:             next_state = state;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= eeprom_pkg::IDLE;
            cmd_valid <= 1'b0;
            ack_error <= 1'b0;
        end
        else
        begin
            cmd_valid <= 1'b0;
            if (accept)
            begin
                req_q     <= req;
                state     <= eeprom_pkg::START;
                cmd_valid <= 1'b1;
                cmd       <= cmd_for(eeprom_pkg::START, req);
                ack_error <= 1'b0;
                rdata     <= '0;      // stays 0 unless the read byte arrives
            end
            else if (state == eeprom_pkg::FINISH)
                state <= eeprom_pkg::IDLE;
            else if (cmd_done)
            begin
                state <= next_state;
                if (next_state != eeprom_pkg::FINISH)
                begin
                    cmd_valid <= 1'b1;
                    cmd       <= cmd_for(next_state, req_q);
                end
                if (nacked)
                    ack_error <= 1'b1;
                if (state == eeprom_pkg::DATA_RD)
                    rdata <= rx_byte;
            end
        end
    end

endmodule

// ==== rtl/i2c_bit_engine.sv ====
module i2c_bit_engine (
    input  logic              CLK,
    input  logic              RESET,
    input  logic              cmd_valid,
    input  i2c_pkg::bit_cmd_t cmd,
    input  logic              phase_tick,
    input  logic [1:0]        quarter,
    output logic              run,
    output logic              cmd_done,
    output i2c_pkg::byte_t    rx_byte,
    output logic              slave_ack,
    input  logic              sda_in,
    output logic              sda_out,
    output logic              sda_oe
);
    i2c_pkg::bit_cmd_e state;
    i2c_pkg::bit_cmd_e op_now;
    i2c_pkg::byte_t    shreg;
    i2c_pkg::byte_t    byte_now;
    i2c_pkg::bit_cnt_t bit_cnt;
    logic              mack_q;
    logic              mack_now;
    logic              active;
    logic              aligned;      // quarter 0 of the first bit has been seen
    logic              take;
    logic              ack_bit;
    logic              framing;

    // a command taken on a quarter 0 tick starts in that same cycle
    assign take     = cmd_valid && !active;
    assign op_now   = take ? cmd.op : state;
    assign byte_now = take ? cmd.tx_byte : shreg;
    assign mack_now = take ? cmd.master_ack : mack_q;

    assign ack_bit  = bit_cnt == i2c_pkg::bit_cnt_t'(i2c_pkg::BITS_PER_BYTE);
    assign framing  = state == i2c_pkg::CMD_START || state == i2c_pkg::CMD_STOP;
    assign cmd_done = aligned && phase_tick && quarter == 2'd3 && (framing || ack_bit);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state   <= i2c_pkg::CMD_STOP;
            active  <= 1'b0;
            aligned <= 1'b0;
            bit_cnt <= '0;
            run     <= 1'b0;
            sda_oe  <= 1'b0;
            sda_out <= 1'b1;
        end
        else
        begin
            if (take)
            begin
                state  <= cmd.op;
                shreg  <= cmd.tx_byte;
                mack_q <= cmd.master_ack;
                active <= 1'b1;
            end

            if ((take || active) && phase_tick)
            begin
                case (quarter)
                    2'd0:
                    begin
                        aligned <= 1'b1;
                        case (op_now)
                            i2c_pkg::CMD_START:
                            begin
                                run    <= 1'b1;
                                sda_oe <= 1'b0;     // sda high before the falling edge
                            end
                            i2c_pkg::CMD_STOP:
                            begin
                                sda_oe  <= 1'b1;
                                sda_out <= 1'b0;
                            end
                            i2c_pkg::CMD_WRITE:
                            begin
                                sda_oe  <= !ack_bit;    // let go for the slave ack
                                sda_out <= byte_now[7];
                                shreg   <= {byte_now[6:0], 1'b0};
                            end
                            default:
                            begin
                                sda_oe  <= ack_bit;
                                sda_out <= mack_now;
                            end
                        endcase
                    end
                    2'd2:
                    begin
                        if (aligned)
                        begin
                            case (state)
                                i2c_pkg::CMD_START:
                                begin
                                    sda_oe  <= 1'b1;    // falls while scl high
                                    sda_out <= 1'b0;
                                end
                                i2c_pkg::CMD_STOP:
                                begin
                                    sda_oe  <= 1'b0;    // rises while scl high
                                    sda_out <= 1'b1;
                                end
                                i2c_pkg::CMD_WRITE:
                                begin
                                    if (ack_bit)
                                        slave_ack <= sda_in;
                                end
                                default:
                                begin
                                    if (!ack_bit)
                                        rx_byte <= {rx_byte[6:0], sda_in};   // msb first
                                end
                            endcase
                        end
                    end
                    2'd3:
                    begin
                        if (cmd_done)
                        begin
                            active  <= 1'b0;
                            aligned <= 1'b0;
                            bit_cnt <= '0;
                            if (state == i2c_pkg::CMD_STOP)
                                run <= 1'b0;
                        end
                        else if (aligned)
                            bit_cnt <= bit_cnt + 1'b1;
                    end
                    default:
                    begin
                        // quarter 1, scl still low
                    end
                endcase
            end
        end
    end

endmodule

// ==== rtl/i2c_pkg.sv ====
package i2c_pkg;

    // one quarter of an scl bit, in CLK cycles
    localparam int QUARTER_CYCLES = 1;
    localparam int BITS_PER_BYTE  = 8;

    localparam int QUARTER_CNT_W  = $clog2(QUARTER_CYCLES + 1);
    localparam int BIT_CNT_W      = $clog2(BITS_PER_BYTE + 1);   // data bits plus ack bit

    typedef logic [BITS_PER_BYTE-1:0] byte_t;
    typedef logic [QUARTER_CNT_W-1:0] quarter_cnt_t;
    typedef logic [BIT_CNT_W-1:0]     bit_cnt_t;

    typedef enum logic [1:0] {
        CMD_START,
        CMD_STOP,
        CMD_WRITE,
        CMD_READ
    } bit_cmd_e;

    typedef struct packed {
        bit_cmd_e op;
        byte_t    tx_byte;
        logic     master_ack;     // low acks the read byte, high nacks it
    } bit_cmd_t;

endpackage

// ==== rtl/scl_gen.sv ====
module scl_gen (
    input  logic       CLK,
    input  logic       RESET,
    input  logic       run,
    output logic       phase_tick,
    output logic [1:0] quarter,
    output logic       scl
);
    i2c_pkg::quarter_cnt_t div_cnt;

    assign phase_tick = div_cnt == i2c_pkg::quarter_cnt_t'(i2c_pkg::QUARTER_CYCLES - 1);

    // low in quarters 0 and 1, idle high when the bus is released
    assign scl = !run || quarter[1];

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            div_cnt <= '0;
            quarter <= 2'd0;
        end
        else
        begin
            if (phase_tick)
                div_cnt <= '0;
            else
                div_cnt <= div_cnt + 1'b1;

            if (!run)
                quarter <= 2'd0;
            else if (phase_tick)
                quarter <= quarter + 2'd1;
        end
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds and runs the testbench, status follows the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module tb_eeprom \
    --Mdir obj_dir -o sim_eeprom \
    && ./obj_dir/sim_eeprom | grep "Simulation passed" \
    && echo "run_sim: PASS" \
    || { echo "run_sim: FAIL"; exit 1; }

// ==== sources.f ====
rtl/i2c_pkg.sv
rtl/eeprom_pkg.sv
rtl/scl_gen.sv
rtl/i2c_bit_engine.sv
rtl/eeprom_seq.sv
rtl/eeprom_ctrl_top.sv
tb/eeprom_slave_model.sv
tb/eeprom_ctrl_sva.sv
tb/tb_eeprom.sv

// ==== tb/eeprom_ctrl_sva.sv ====
module eeprom_ctrl_sva (
    input logic CLK,
    input logic RESET,
    input logic req_valid,
    input logic busy,
    input logic done,
    input logic scl,
    input logic sda_out,
    input logic sda_oe
);
    logic pull;
    logic pending;      // accepted request still waiting for its done

    assign pull = sda_oe && !sda_out;

    always_ff @(posedge CLK)
    begin
        if (RESET)
            pending <= 1'b0;
        else if (req_valid && !busy)
            pending <= 1'b1;
        else if (done)
            pending <= 1'b0;
    end

    done_single: assert property (@(posedge CLK) disable iff (RESET) done |=> !done)
        else $error("done held high for two cycles");

    // a request seen while busy opens nothing
    done_per_request: assert property (@(posedge CLK) disable iff (RESET) done |-> pending)
        else $error("done without an accepted request");

    // with scl high, sda only falls for a start and only rises for the stop
    start_in_busy: assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && pull && !$past(pull)) |-> busy)
        else $error("sda pulled low with scl high outside a request");

    stop_then_done: assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && !pull && $past(pull)) |=> done)
        else $error("sda released with scl high other than at stop");

    oe_after_reset: assert property (@(posedge CLK) $fell(RESET) |-> !sda_oe)
        else $error("sda_oe high after reset");

endmodule

bind eeprom_ctrl_top eeprom_ctrl_sva u_sva (
    .CLK       (CLK),
    .RESET     (RESET),
    .req_valid (req_valid),
    .busy      (busy),
    .done      (done),
    .scl       (scl),
    .sda_out   (sda_out),
    .sda_oe    (sda_oe)
);

// ==== tb/eeprom_slave_model.sv ====
module eeprom_slave_model (
    input  logic CLK,
    input  logic RESET,
    input  logic scl,
    input  logic sda,
    input  logic nack_force,
    output logic sda_low
);
    logic [7:0]  mem [0:2047];
    logic [7:0]  shift;
    logic [7:0]  out_byte;
    logic [10:0] ptr;
    logic        scl_q;
    logic        sda_q;
    logic        in_frame;
    logic        rd_mode;
    logic        rd_done;
    logic        ack_ok;
    int          bit_cnt;
    int          byte_idx;

    // only the control byte carries the device code
    assign ack_ok = !nack_force && (byte_idx != 0 || shift[7:4] == 4'b1010);

    // pins are sampled on CLK, so edges show up one cycle late
    always @(posedge CLK)
    begin
        if (RESET)
        begin
            for (int i = 0; i < 2048; i++)
                mem[i] <= 8'hFF;
            scl_q    <= 1'b1;
            sda_q    <= 1'b1;
            sda_low  <= 1'b0;
            in_frame <= 1'b0;
            rd_mode  <= 1'b0;
            rd_done  <= 1'b0;
            bit_cnt  <= 0;
            byte_idx <= 0;
            ptr      <= '0;
            shift    <= '0;
            out_byte <= '0;
        end
        else
        begin
            scl_q <= scl;
            sda_q <= sda;
            if (scl && scl_q && sda_q && !sda)
            begin
                in_frame <= 1'b1;     // start or repeated start
                rd_mode  <= 1'b0;
                rd_done  <= 1'b0;
                bit_cnt  <= 0;
                byte_idx <= 0;
                sda_low  <= 1'b0;
            end
            else if (scl && scl_q && !sda_q && sda)
            begin
                in_frame <= 1'b0;     // stop
                sda_low  <= 1'b0;
            end
            else if (in_frame && scl && !scl_q)
            begin
                bit_cnt <= bit_cnt + 1;
                if (bit_cnt < 8)
                    shift <= {shift[6:0], sda};
            end
            else if (in_frame && !scl && scl_q)
            begin
                if (bit_cnt == 8 && !rd_mode)
                begin
                    sda_low <= ack_ok;
                    if (!ack_ok)
                        in_frame <= 1'b0;
                    else if (byte_idx == 0 && shift[0])
                    begin
                        rd_mode  <= 1'b1;
                        out_byte <= mem[ptr];
                    end
                    else if (byte_idx == 0)
                        ptr[10:8] <= shift[3:1];
                    else if (byte_idx == 1)
                        ptr[7:0] <= shift;
                    else
                        mem[ptr] <= shift;
                    byte_idx <= byte_idx + 1;
                end
                else if (bit_cnt == 8)
                begin
                    sda_low <= 1'b0;  // master acks here
                    rd_done <= 1'b1;
                end
                else if (bit_cnt == 9)
                begin
                    bit_cnt  <= 0;
                    sda_low  <= rd_mode && !rd_done && !out_byte[7];
                    out_byte <= {out_byte[6:0], 1'b0};
                end
                else if (rd_mode && !rd_done && bit_cnt > 0)
                begin
                    sda_low  <= !out_byte[7];
                    out_byte <= {out_byte[6:0], 1'b0};
                end
            end
        end
    end

endmodule

// ==== tb/tb_eeprom.sv ====
module tb_eeprom;

    localparam int NUM_REQ   = 54;
    localparam int LIMIT_CYC = NUM_REQ * 2000;

    logic                  CLK;
    logic                  RESET;
    logic                  req_valid;
    eeprom_pkg::host_req_t req;
    logic                  busy;
    logic                  done;
    eeprom_pkg::mem_data_t rdata;
    logic                  ack_error;
    logic                  scl;
    logic                  sda;
    logic                  sda_out;
    logic                  sda_oe;
    logic                  slave_low;
    logic                  nack_force;

    eeprom_pkg::mem_data_t shadow [0:2047];
    eeprom_pkg::host_req_t cur_req;
    logic                  cur_nack;
    eeprom_pkg::mem_data_t last_rdata;
    int                    done_cnt;
    int                    accepted;

    // wired AND of both open-drain drivers
    assign sda = !(sda_oe && !sda_out) && !slave_low;

    eeprom_ctrl_top u_eeprom_ctrl_top (
        .CLK       (CLK),
        .RESET     (RESET),
        .req_valid (req_valid),
        .req       (req),
        .busy      (busy),
        .done      (done),
        .rdata     (rdata),
        .ack_error (ack_error),
        .scl       (scl),
        .sda_in    (sda),
        .sda_out   (sda_out),
        .sda_oe    (sda_oe)
    );

    eeprom_slave_model u_slave (
        .CLK        (CLK),
        .RESET      (RESET),
        .scl        (scl),
        .sda        (sda),
        .nack_force (nack_force),
        .sda_low    (slave_low)
    );

    function automatic eeprom_pkg::mem_data_t expected_read(input eeprom_pkg::mem_addr_t a);
        return shadow[a];
    endfunction

    task automatic check(input string what, input int got, input int exp);
        if (got != exp)
        begin
            $display("[ERROR] %0t: %s got %0h expected %0h", $time, what, got, exp);
            $display("Simulation failed");
            $fatal(1, "mismatch");
        end
    endtask

    // one request; optionally pokes req_valid again while busy
    task automatic run_request(input logic is_read, input eeprom_pkg::mem_addr_t addr,
                               input eeprom_pkg::mem_data_t wdata, input logic poke);
        int start_cnt;
        start_cnt = done_cnt;
        cur_req   = '{is_read: is_read, addr: addr, wdata: wdata};
        cur_nack  = nack_force;
        check("busy before request", 32'(busy), 0);
        req       = cur_req;
        req_valid = 1'b1;
        @(posedge CLK);
        #1;
        req_valid = 1'b0;
        accepted++;
        if (poke)
        begin
            repeat (5) @(posedge CLK);
            #1;
            check("busy at second request", 32'(busy), 1);
            req       = ~cur_req;
            req_valid = 1'b1;
            @(posedge CLK);
            #1;
            req_valid = 1'b0;
        end
        do
        begin
            @(posedge CLK);
            #1;
        end
        while (done_cnt == start_cnt);
    endtask

    initial
    begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    always @(posedge CLK)
    begin
        if (RESET)
        begin
            for (int i = 0; i < 2048; i++)
                shadow[i] = 8'hFF;
            done_cnt <= 0;
        end
        else if (done)
        begin
            done_cnt   <= done_cnt + 1;
            last_rdata <= rdata;
            if (cur_nack)
            begin
                check("ack_error on nack", 32'(ack_error), 1);
                check("rdata on nack", 32'(rdata), 0);
            end
            else
            begin
                check("ack_error", 32'(ack_error), 0);
                if (cur_req.is_read)
                    check("read data", 32'(rdata), 32'(expected_read(cur_req.addr)));
                else if (!ack_error)
                    shadow[cur_req.addr] = cur_req.wdata;
            end
        end
    end

    initial
    begin
        repeat (LIMIT_CYC) @(posedge CLK);
        $display("Timeout: the controller stopped answering requests");
        $display("Simulation failed");
        $fatal(1, "timeout");
    end

    initial
    begin
        eeprom_pkg::mem_addr_t pair_addr [4];
        eeprom_pkg::mem_data_t wd;
        eeprom_pkg::mem_addr_t ra;
        pair_addr = '{11'h005, 11'h1a3, 11'h3c7, 11'h6f0};
        void'($urandom(32'h7fe4));
        RESET      = 1'b1;
        req_valid  = 1'b0;
        req        = '0;
        nack_force = 1'b0;
        cur_req    = '0;
        cur_nack   = 1'b0;
        accepted   = 0;
        repeat (3) @(posedge CLK);
        #1;
        RESET = 1'b0;

        check("busy after reset", 32'(busy), 0);
        check("done after reset", 32'(done), 0);
        check("scl after reset", 32'(scl), 1);
        check("sda_oe after reset", 32'(sda_oe), 0);

        // page bits in addr[10:8] differ across these
        for (int i = 0; i < 4; i++)
        begin
            wd = 8'($urandom);
            run_request(1'b0, pair_addr[i], wd, 1'b0);
            run_request(1'b1, pair_addr[i], 8'h00, 1'b0);
            check("write then read", 32'(last_rdata), 32'(wd));
        end

        for (int i = 0; i < 40; i++)
        begin
            ra = 11'($urandom % 8) * 11'd257;
            run_request(1'($urandom % 2), ra, 8'($urandom), 1'b0);
        end

        run_request(1'b1, 11'h7ff, 8'h00, 1'b0);
        check("unwritten address", 32'(last_rdata), 32'h0ff);

        nack_force = 1'b1;
        run_request(1'b0, 11'h1a3, 8'h5a, 1'b0);
        run_request(1'b1, 11'h1a3, 8'h00, 1'b0);
        nack_force = 1'b0;
        run_request(1'b1, 11'h1a3, 8'h00, 1'b0);

        // the ignored request must not disturb the write in flight
        run_request(1'b0, 11'h222, 8'h3c, 1'b1);
        run_request(1'b1, 11'h222, 8'h00, 1'b0);
        check("read after ignored request", 32'(last_rdata), 32'h03c);
        repeat (20) @(posedge CLK);
        #1;
        check("done count", done_cnt, accepted);

        $display("Simulation passed");
        $finish;
    end

endmodule
